//--- Bender.yml
package:
  name: clk_ctrl

sources:
  - clkCtrlPkg.sv
  - regBusIf.sv
  - axiLiteRegBridge.sv
  - clkAndDataRegs.sv
  - ncoClkGen.sv
  - clkCtrlTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - clkCtrlTb.sv

//--- axiLiteRegBridge.sv
/*
 * AXI4-Lite slave bridge, one write and one read outstanding
 * turns each transaction into a single local register bus cycle
 */
`default_nettype none

module axiLiteRegBridge import clkCtrlPkg::*; (
    input  wire                   busClk,
    input  wire                   rstN,
    // write address channel
    input  wire [addrWidth-1:0]   awaddr,
    input  wire                   awvalid,
    output logic                  awready,
    // write data channel
    input  wire [dataWidth-1:0]   wdata,
    input  wire [dataWidth/8-1:0] wstrb,
    input  wire                   wvalid,
    output logic                  wready,
    // write response channel
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  wire                   bready,
    // read address channel
    input  wire [addrWidth-1:0]   araddr,
    input  wire                   arvalid,
    output logic                  arready,
    // read data channel
    output logic [dataWidth-1:0]  rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  wire                   rready,
    regBusIf.host                 bus
);

    logic                   awCap;    // write address held
    logic                   wCap;     // write data held
    logic                   arCap;    // read address held
    logic [addrWidth-1:0]   awAddrQ;
    logic [addrWidth-1:0]   arAddrQ;
    logic [dataWidth-1:0]   wDataQ;
    logic [dataWidth/8-1:0] wStrbQ;
    logic                   csQ;      // bus cycle last clock
    logic                   wrGo;
    logic                   rdGo;

    // a captured channel stays closed until its response handshake
    assign awready = !awCap;
    assign wready  = !wCap;
    assign arready = !arCap;

    // one bus cycle per transaction, never two cycles back to back
    // a read waits one cycle when a write bus cycle is due
    assign wrGo = awCap && wCap && !bvalid && !csQ;
    assign rdGo = arCap && !rvalid && !csQ && !wrGo;

    assign bus.cs   = wrGo || rdGo;
    assign bus.addr = wrGo ? awAddrQ : arAddrQ;
    assign bus.din  = wDataQ;
    assign bus.wr0  = wrGo && wStrbQ[0];
    assign bus.wr1  = wrGo && wStrbQ[1];
    assign bus.wr2  = wrGo && wStrbQ[2];
    assign bus.wr3  = wrGo && wStrbQ[3];

    // channel and response state
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            awCap  <= 1'b0;
            wCap   <= 1'b0;
            arCap  <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            csQ    <= 1'b0;
        end else begin
            csQ <= bus.cs;

            if (bvalid && bready) begin
                awCap  <= 1'b0;
                wCap   <= 1'b0;
                bvalid <= 1'b0;
            end else begin
                if (awvalid && awready)
                    awCap <= 1'b1;
                if (wvalid && wready)
                    wCap <= 1'b1;
                if (wrGo)
                    bvalid <= 1'b1;  // one cycle after the register write
            end

            if (rvalid && rready) begin
                arCap  <= 1'b0;
                rvalid <= 1'b0;
            end else begin
                if (arvalid && arready)
                    arCap <= 1'b1;
                if (rdGo)
                    rvalid <= 1'b1;
            end
        end
    end

    // captured payload and responses
    always_ff @(posedge busClk) begin
        if (awvalid && awready)
            awAddrQ <= awaddr;
        if (wvalid && wready) begin
            wDataQ <= wdata;
            wStrbQ <= wstrb;
        end
        if (arvalid && arready)
            arAddrQ <= araddr;
        if (wrGo)
            bresp <= bus.hit ? respOkay : respSlvErr;
        if (rdGo) begin
            rdata <= bus.hit ? bus.dout : '0;  // misses read zero
            rresp <= bus.hit ? respOkay : respSlvErr;
        end
    end

    // responses wait for the host
    bHold: assert property (@(posedge busClk) disable iff (!rstN)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid or bresp changed before bready");

    rHold: assert property (@(posedge busClk) disable iff (!rstN)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid or read data changed before rready");

    csSingle: assert property (@(posedge busClk) disable iff (!rstN)
        bus.cs |=> !bus.cs)
        else $error("cs held for two cycles");

endmodule

`default_nettype wire

//--- build.f
+incdir+.
clkCtrlPkg.sv
regBusIf.sv
axiLiteRegBridge.sv
clkAndDataRegs.sv
ncoClkGen.sv
clkCtrlTop.sv
clkCtrlTb.sv

//--- clkAndDataRegs.sv
/*
 * clock-and-data register bank
 * space decode, byte lane writes and masked readback
 */
`default_nettype none

module clkAndDataRegs import clkCtrlPkg::*; (
    input  wire                    busClk,
    input  wire                    rstN,
    regBusIf.regs                  bus,
    output logic [3:0]             source,
    output logic [1:0]             clkPhase,
    output logic                   finalOutputSelect,
    output logic                   clkReset,
    output logic [phaseWidth-1:0]  centerFreq,
    output logic [4:0]             loopGain,
    output logic [7:0]             feedbackDivider
);

    logic                 inSpace;
    logic [3:0]           offset;
    logic [dataWidth-1:0] ctrlWord;
    logic [dataWidth-1:0] gainsWord;

    assign offset  = bus.addr[3:0];
    assign inSpace = bus.cs && (bus.addr[addrWidth-1:4] == cAndDSpace);

    // only the four defined offsets answer
    always_comb begin
        case (offset)
            regControl, regCenterFreq, regGains, regFdbkDiv:
                bus.hit = inSpace;
            default:
                bus.hit = 1'b0;
        endcase
    end

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            source            <= '0;
            clkPhase          <= '0;
            finalOutputSelect <= 1'b0;
            clkReset          <= 1'b0;
            centerFreq        <= '0;
            loopGain          <= '0;
            feedbackDivider   <= '0;
        end else if (bus.hit) begin
            if (bus.wr0) begin
                case (offset)
                    regControl:    source           <= bus.din[3:0];
                    regCenterFreq: centerFreq[7:0]  <= bus.din[7:0];
                    regGains:      loopGain         <= bus.din[4:0];
                    default: ;
                endcase
            end
            if (bus.wr1) begin
                case (offset)
                    regControl:    clkPhase         <= bus.din[ctrlPhaseLsb +: 2];
                    regCenterFreq: centerFreq[15:8] <= bus.din[15:8];
                    default: ;
                endcase
            end
            if (bus.wr2) begin
                case (offset)
                    regCenterFreq: centerFreq[23:16] <= bus.din[23:16];
                    regFdbkDiv:    feedbackDivider   <= bus.din[fdbkDivLsb +: 8];
                    default: ;
                endcase
            end
            if (bus.wr3) begin
                case (offset)
                    regControl: begin
                        finalOutputSelect <= bus.din[ctrlOutSelBit];
                        clkReset          <= bus.din[ctrlResetBit];
                    end
                    regCenterFreq: centerFreq[31:24] <= bus.din[31:24];
                    default: ;
                endcase
            end
        end
    end

    // readback words, masked to implemented bits
    always_comb begin
        ctrlWord                     = '0;
        ctrlWord[3:0]                = source;
        ctrlWord[ctrlPhaseLsb +: 2]  = clkPhase;
        ctrlWord[ctrlOutSelBit]      = finalOutputSelect;
        ctrlWord[ctrlResetBit]       = clkReset;
        ctrlWord                     = ctrlWord & controlMask;

        gainsWord                    = '0;
        gainsWord[4:0]               = loopGain;
        gainsWord[fdbkDivLsb +: 8]   = feedbackDivider;
        gainsWord                    = gainsWord & gainsMask;
    end

    always_comb begin
        bus.dout = '0;  // misses read zero
        if (bus.hit) begin
            case (offset)
                regControl:           bus.dout = ctrlWord;
                regCenterFreq:        bus.dout = centerFreq;
                regGains, regFdbkDiv: bus.dout = gainsWord;  // same word at both
                default: ;
            endcase
        end
    end

    // write lanes only come with a bus cycle from the bridge
    wrNeedsCs: assert property (@(posedge busClk) disable iff (!rstN)
        !bus.cs |-> !(bus.wr0 || bus.wr1 || bus.wr2 || bus.wr3))
        else $error("write lane high without cs");

endmodule

`default_nettype wire

//--- clkCtrlPkg.sv
/*
 * clock control package
 * address map, field positions, response codes and generator widths
 */
`default_nettype none

package clkCtrlPkg;

    // bus widths
    localparam int addrWidth = 13;
    localparam int dataWidth = 32;

    // addr[12:4] of the clock-and-data space, base 0x400
    localparam logic [8:0] cAndDSpace = 9'h040;

    // register offsets inside the space
    localparam logic [3:0] regControl    = 4'h0;
    localparam logic [3:0] regCenterFreq = 4'h4;
    localparam logic [3:0] regGains      = 4'h8;
    localparam logic [3:0] regFdbkDiv    = 4'hC;

    // CONTROL field positions, source sits at bit 0
    localparam int ctrlPhaseLsb  = 8;
    localparam int ctrlOutSelBit = 24;
    localparam int ctrlResetBit  = 31;

    // GAINS / FDBK_DIV share this layout, loopGain at bit 0
    localparam int fdbkDivLsb = 16;

    // implemented bits on readback
    localparam logic [31:0] controlMask = 32'h8100_030F;
    localparam logic [31:0] gainsMask   = 32'h00FF_001F;

    // AXI response codes
    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    // phase accumulator
    localparam int phaseWidth = 32;

endpackage

`default_nettype wire

//--- clkCtrlTbTasks.svh
/*
 * AXI4-Lite host tasks and the register reference model
 */
`ifndef clkCtrlTbTasksSvh
`define clkCtrlTbTasksSvh

    // space match and one of the four defined offsets
    function automatic logic hitsReg(input logic [addrWidth-1:0] a);
        return a[addrWidth-1:4] == cAndDSpace &&
               (a[3:0] == regControl || a[3:0] == regCenterFreq ||
                a[3:0] == regGains || a[3:0] == regFdbkDiv);
    endfunction

    function automatic logic [dataWidth-1:0] expectedWord(input logic [addrWidth-1:0] a);
        if (!hitsReg(a))
            return '0;  // misses read zero
        case (a[3:0])
            regControl:    return expCtrl;
            regCenterFreq: return expCf;
            default:       return expGains;  // GAINS and FDBK_DIV share one word
        endcase
    endfunction

    function automatic void modelWrite(input logic [addrWidth-1:0] a,
                                       input logic [dataWidth-1:0] d,
                                       input logic [3:0] s);
        logic [dataWidth-1:0] lanes;
        logic [dataWidth-1:0] m;
        lanes = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        if (!hitsReg(a))
            return;
        case (a[3:0])
            regControl:    m = controlMask;
            regCenterFreq: m = '1;
            regGains:      m = gainsMask & 32'h0000_00FF;  // loopGain lane only
            default:       m = gainsMask & 32'h00FF_0000;  // divider lane only
        endcase
        m = m & lanes;
        case (a[3:0])
            regControl:    expCtrl  = (expCtrl & ~m) | (d & m);
            regCenterFreq: expCf    = (expCf & ~m) | (d & m);
            default:       expGains = (expGains & ~m) | (d & m);
        endcase
    endfunction

    // AW and W offered together, each drops after its own handshake
    task automatic writeReg(input logic [addrWidth-1:0] a, input logic [dataWidth-1:0] d,
                            input logic [3:0] s, input int hold);
        logic [1:0] expResp;
        @(negedge busClk);
        awaddr  = a;
        awvalid = 1'b1;
        wdata   = d;
        wstrb   = s;
        wvalid  = 1'b1;
        if (hold > 0)
            bready = 1'b0;
        fork
            begin
                while (!awready) @(negedge busClk);
                @(negedge busClk);
                awvalid = 1'b0;
            end
            begin
                while (!wready) @(negedge busClk);
                @(negedge busClk);
                wvalid = 1'b0;
            end
        join
        while (!bvalid) @(negedge busClk);
        repeat (hold) @(negedge busClk);  // back-pressure span
        bready  = 1'b1;
        expResp = hitsReg(a) ? respOkay : respSlvErr;
        assert (bresp == expResp)
            else logError($sformatf("bresp %b at %h, expected %b", bresp, a, expResp));
        modelWrite(a, d, s);
        assert (source == expCtrl[3:0])
            else logError($sformatf("source %h, expected %h", source, expCtrl[3:0]));
        assert (loopGain == expGains[4:0])
            else logError($sformatf("loopGain %h, expected %h", loopGain, expGains[4:0]));
    endtask

    task automatic readReg(input logic [addrWidth-1:0] a, input int hold,
                           output logic [dataWidth-1:0] data);
        logic [1:0] expResp;
        @(negedge busClk);
        araddr  = a;
        arvalid = 1'b1;
        if (hold > 0)
            rready = 1'b0;
        while (!arready) @(negedge busClk);
        @(negedge busClk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge busClk);
        repeat (hold) @(negedge busClk);
        data    = rdata;
        rready  = 1'b1;
        expResp = hitsReg(a) ? respOkay : respSlvErr;
        assert (rresp == expResp)
            else logError($sformatf("rresp %b at %h, expected %b", rresp, a, expResp));
        assert (data == expectedWord(a))
            else logError($sformatf("rdata %h at %h, expected %h", data, a, expectedWord(a)));
    endtask

`endif

//--- clkCtrlTb.sv
/*
 * testbench for the clock control subsystem
 * AXI register traffic, back-pressure and NCO lockstep checks
 */
`default_nettype none

module clkCtrlTb import clkCtrlPkg::*; ();

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 10;
    localparam int numTxns     = 190;  // upper bound over all tests
    localparam int txnCycles   = 14;   // longest hold plus handshakes
    localparam int ncoCases    = 4;
    localparam int ncoWindow   = 320;
    localparam int watchdogCycles =
        resetCycles + numTxns * txnCycles + ncoCases * (ncoWindow + 30) + 500;

    logic                   busClk;
    logic                   rstN;
    logic [addrWidth-1:0]   awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [dataWidth-1:0]   wdata;
    logic [dataWidth/8-1:0] wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [addrWidth-1:0]   araddr;
    logic                   arvalid;
    logic                   arready;
    logic [dataWidth-1:0]   rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;
    logic                   clkOut;
    logic                   ncoOut;
    logic                   divOut;
    logic [3:0]             source;
    logic [4:0]             loopGain;
    int                     errCount;
    logic [dataWidth-1:0]   expCtrl;   // reference register words
    logic [dataWidth-1:0]   expCf;
    logic [dataWidth-1:0]   expGains;  // shared by GAINS and FDBK_DIV

    clkCtrlTop DUT (.*);

    task automatic logError(input string msg);
        errCount++;
        $display("error at %0t: %s", $time, msg);
    endtask

    `include "clkCtrlTbTasks.svh"

    initial begin
        busClk = 1'b0;
        forever #(clkPeriod / 2) busClk = ~busClk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired before the test sequence finished");
        $display("Errors found");
        $finish;
    end

    bHeld: assert property (@(posedge busClk) disable iff (!rstN)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else logError("bvalid or bresp moved while bready low");

    rHeld: assert property (@(posedge busClk) disable iff (!rstN)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else logError("rvalid or read data moved while rready low");

    // no new write or read accepted while a response waits
    awClosed: assert property (@(posedge busClk) disable iff (!rstN)
        bvalid |-> !awready && !wready)
        else logError("write channel open while bvalid pending");

    arClosed: assert property (@(posedge busClk) disable iff (!rstN)
        rvalid |-> !arready)
        else logError("read channel open while rvalid pending");

    resetState: assert property (@(posedge busClk) $rose(rstN) |->
        awready && wready && arready && !bvalid && !rvalid && source == '0 && loopGain == '0)
        else logError("bus or register state not idle after reset");

    // lockstep model of accumulator, quarter-cycle offset and divider
    task automatic ncoCheck(input logic [phaseWidth-1:0] cf, input logic [1:0] ph,
                            input logic [7:0] fd, input logic sel);
        logic [dataWidth-1:0]  ctrl;
        logic [phaseWidth-1:0] acc;
        logic [phaseWidth-1:0] sum;
        logic                  ncoExp;
        logic                  divExp;
        logic                  ncoLast;
        logic                  divLast;
        logic                  ncoDutLast;
        logic                  divDutLast;
        int                    ncoRisesExp;
        int                    ncoRisesDut;
        int                    divRisesExp;
        int                    divRisesDut;
        ctrl = (expCtrl & 32'h0000_000F) | (32'(sel) << ctrlOutSelBit) |
               (32'(ph) << ctrlPhaseLsb);
        writeReg({cAndDSpace, regCenterFreq}, cf, 4'hF, 0);
        writeReg({cAndDSpace, regFdbkDiv}, {8'h00, fd, 16'h0000}, 4'h4, 0);
        writeReg({cAndDSpace, regControl}, ctrl | (32'd1 << ctrlResetBit), 4'hF, 0);
        repeat (4) @(negedge busClk);
        writeReg({cAndDSpace, regControl}, ctrl, 4'hF, 0);  // release lands with bvalid
        acc         = '0;
        ncoLast     = ph[1];  // accumulator still at zero
        divLast     = (fd == 8'd0) ? ph[1] : 1'b0;
        ncoDutLast  = ncoOut;
        divDutLast  = divOut;
        ncoRisesExp = 0;
        ncoRisesDut = 0;
        divRisesExp = 0;
        divRisesDut = 0;
        repeat (ncoWindow) begin
            @(negedge busClk);
            sum    = acc + (phaseWidth'(ph) << 30);  // one quarter cycle is 2^30
            ncoExp = sum[phaseWidth-1];
            divExp = (fd == 8'd0) ? ncoExp : 1'((ncoRisesExp / fd) % 2);
            acc    = acc + cf;
            assert (ncoOut === ncoExp)
                else logError($sformatf("ncoOut %b, expected %b", ncoOut, ncoExp));
            assert (divOut === divExp)
                else logError($sformatf("divOut %b, expected %b", divOut, divExp));
            assert (clkOut === (sel ? divExp : ncoExp))
                else logError($sformatf("clkOut %b with select %b", clkOut, sel));
            if (ncoExp && !ncoLast)
                ncoRisesExp++;
            if (ncoOut && !ncoDutLast)
                ncoRisesDut++;
            if (divExp && !divLast)
                divRisesExp++;
            if (divOut && !divDutLast)
                divRisesDut++;
            ncoLast    = ncoExp;
            divLast    = divExp;
            ncoDutLast = ncoOut;
            divDutLast = divOut;
        end
        assert (ncoRisesDut == ncoRisesExp)
            else logError($sformatf("%0d ncoOut edges, expected %0d", ncoRisesDut, ncoRisesExp));
        assert (divRisesDut == divRisesExp)
            else logError($sformatf("%0d divOut edges, expected %0d", divRisesDut, divRisesExp));
    endtask

    initial begin
        logic [dataWidth-1:0] rd;
        logic [dataWidth-1:0] rdAlt;
        logic [addrWidth-1:0] badAddr [9];
        logic [3:0]           off;
        void'($urandom(32'h174a7c9a));
        errCount = 0;
        expCtrl  = '0;
        expCf    = '0;
        expGains = '0;
        rstN     = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b1;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b1;
        badAddr  = '{13'h0000, 13'h03FC, 13'h0410, 13'h1400, 13'h0401,
                     13'h0402, 13'h0406, 13'h040B, 13'h040F};
        repeat (resetCycles) @(negedge busClk);
        rstN = 1'b1;

        // full-strobe writes, masked readback
        repeat (8) begin
            for (int r = 0; r < 4; r++)
                writeReg({cAndDSpace, 4'(r * 4)}, $urandom, 4'hF, 0);
            for (int r = 0; r < 4; r++)
                readReg({cAndDSpace, 4'(r * 4)}, 0, rd);
            readReg({cAndDSpace, regGains}, 0, rd);
            readReg({cAndDSpace, regFdbkDiv}, 0, rdAlt);
            assert (rd == rdAlt)
                else logError($sformatf("GAINS %h and FDBK_DIV %h differ", rd, rdAlt));
        end

        // partial strobes
        repeat (24) begin
            off = 4'($urandom_range(3)) << 2;
            writeReg({cAndDSpace, off}, $urandom, 4'($urandom), 0);
            readReg({cAndDSpace, off}, 0, rd);
        end

        // misses answer SLVERR and leave the bank alone
        foreach (badAddr[i]) begin
            writeReg(badAddr[i], $urandom, 4'hF, 0);
            readReg(badAddr[i], 0, rd);
        end
        for (int r = 0; r < 4; r++)
            readReg({cAndDSpace, 4'(r * 4)}, 0, rd);

        // host back-pressure on B and R
        repeat (10) begin
            off = 4'($urandom_range(3)) << 2;
            writeReg({cAndDSpace, off}, $urandom, 4'hF, 1 + $urandom_range(7));
            readReg({cAndDSpace, off}, 1 + $urandom_range(7), rd);
        end

        ncoCheck(32'h0800_0000, 2'd0, 8'd3, 1'b1);
        ncoCheck(32'h0CCC_CCCD, 2'd2, 8'd0, 1'b1);  // zero divider passes ncoOut
        ncoCheck(32'h1000_0000, 2'd1, 8'd2, 1'b0);
        ncoCheck({4'h0, 28'($urandom)} | 32'h0100_0000, 2'($urandom),
                 8'(1 + $urandom_range(3)), 1'b1);

        $display("test sequence done, %0d errors", errCount);
        if (errCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- clkCtrlTop.sv
/*
 * clock control subsystem top
 * AXI4-Lite bridge, clock-and-data registers and NCO clock generator
 */
`default_nettype none

module clkCtrlTop import clkCtrlPkg::*; (
    input  wire                   busClk,
    input  wire                   rstN,
    input  wire [addrWidth-1:0]   awaddr,
    input  wire                   awvalid,
    output wire                   awready,
    input  wire [dataWidth-1:0]   wdata,
    input  wire [dataWidth/8-1:0] wstrb,
    input  wire                   wvalid,
    output wire                   wready,
    output wire [1:0]             bresp,
    output wire                   bvalid,
    input  wire                   bready,
    input  wire [addrWidth-1:0]   araddr,
    input  wire                   arvalid,
    output wire                   arready,
    output wire [dataWidth-1:0]   rdata,
    output wire [1:0]             rresp,
    output wire                   rvalid,
    input  wire                   rready,
    output wire                   clkOut,
    output wire                   ncoOut,
    output wire                   divOut,
    output wire [3:0]             source,    // to external source mux
    output wire [4:0]             loopGain   // to external loop logic
);

    wire [phaseWidth-1:0] centerFreq;
    wire [1:0]            clkPhase;
    wire                  finalOutputSelect;
    wire                  clkReset;
    wire [7:0]            feedbackDivider;

    regBusIf bus ();

    axiLiteRegBridge uBridge (
        .busClk  (busClk),
        .rstN    (rstN),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .bus     (bus.host)
    );

    clkAndDataRegs uRegs (
        .busClk            (busClk),
        .rstN              (rstN),
        .bus               (bus.regs),
        .source            (source),
        .clkPhase          (clkPhase),
        .finalOutputSelect (finalOutputSelect),
        .clkReset          (clkReset),
        .centerFreq        (centerFreq),
        .loopGain          (loopGain),
        .feedbackDivider   (feedbackDivider)
    );

    ncoClkGen uNco (
        .busClk            (busClk),
        .rstN              (rstN),
        .centerFreq        (centerFreq),
        .clkPhase          (clkPhase),
        .clkReset          (clkReset),
        .feedbackDivider   (feedbackDivider),
        .finalOutputSelect (finalOutputSelect),
        .ncoOut            (ncoOut),
        .divOut            (divOut),
        .clkOut            (clkOut)
    );

endmodule

`default_nettype wire

//--- ncoClkGen.sv
/*
 * numerically controlled clock generator
 * phase accumulator, quarter-cycle offset, feedback divider, output select
 */
`default_nettype none

module ncoClkGen import clkCtrlPkg::*; (
    input  wire                   busClk,
    input  wire                   rstN,
    input  wire [phaseWidth-1:0]  centerFreq,
    input  wire [1:0]             clkPhase,
    input  wire                   clkReset,
    input  wire [7:0]             feedbackDivider,
    input  wire                   finalOutputSelect,
    output logic                  ncoOut,
    output logic                  divOut,
    output logic                  clkOut
);

    logic [phaseWidth-1:0] acc;
    logic [phaseWidth-1:0] shiftedPhase;
    logic                  ncoPrev;
    logic                  ncoRise;
    logic [7:0]            riseCnt;
    logic                  divQ;

    // quarter-cycle steps land on the top two bits
    assign shiftedPhase = acc + {clkPhase, {(phaseWidth-2){1'b0}}};

    always_ff @(posedge busClk) begin
        if (!rstN || clkReset) begin
            acc <= '0;
        end else begin
            acc <= acc + centerFreq;
        end
    end

    // registered top bit, one cycle behind the accumulator
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            ncoOut  <= 1'b0;
            ncoPrev <= 1'b0;
        end else begin
            ncoOut  <= shiftedPhase[phaseWidth-1];
            ncoPrev <= ncoOut;
        end
    end

    assign ncoRise = ncoOut && !ncoPrev;

    // toggle once per feedbackDivider rising edges
    always_ff @(posedge busClk) begin
        if (!rstN || clkReset) begin
            riseCnt <= '0;
            divQ    <= 1'b0;
        end else if (ncoRise && feedbackDivider != 8'd0) begin
            if (riseCnt >= feedbackDivider - 8'd1) begin
                riseCnt <= '0;
                divQ    <= !divQ;
            end else begin
                riseCnt <= riseCnt + 8'd1;
            end
        end
    end

    assign divOut = (feedbackDivider == 8'd0) ? ncoOut : divQ;  // zero bypasses
    assign clkOut = finalOutputSelect ? divOut : ncoOut;

endmodule

`default_nettype wire

//--- regBusIf.sv
/*
 * local register bus between the AXI bridge and the register bank
 */
`default_nettype none

interface regBusIf import clkCtrlPkg::*; ();

    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] din;
    logic [dataWidth-1:0] dout;  // combinational from addr and cs
    logic                 cs;    // one cycle per access
    logic                 wr0;   // byte lane write enables
    logic                 wr1;
    logic                 wr2;
    logic                 wr3;
    logic                 hit;   // access decoded to a defined register

    // bridge side
    modport host (
        output addr, din, cs, wr0, wr1, wr2, wr3,
        input  dout, hit
    );

    // register bank side
    modport regs (
        input  addr, din, cs, wr0, wr1, wr2, wr3,
        output dout, hit
    );

endinterface

`default_nettype wire
